//--- design/i2c_ctrl_pkg.sv
// I2C controller shared definitions
`default_nettype none

package i2c_ctrl_pkg;

    // Command codes carried in the top bits of a queue entry
    localparam int CMD_W = 2;

    localparam logic [CMD_W-1:0] CMD_START     = 2'd0;
    localparam logic [CMD_W-1:0] CMD_WRITE     = 2'd1;
    localparam logic [CMD_W-1:0] CMD_READ      = 2'd2;
    localparam logic [CMD_W-1:0] CMD_READ_LAST = 2'd3;

    // Entry layout is {cmd, stop, payload}
    localparam int ENTRY_W  = 11;
    localparam int STOP_BIT = 8;

    // Interrupt vector bit positions
    localparam int INT_W        = 3;
    localparam int INT_TX_EMPTY = 0;
    localparam int INT_RX_FULL  = 1;
    localparam int INT_ERROR    = 2;

    // Payload byte of an entry
    // addr view: [7:1] target address, [0] rw (1 for read)
    // data view: raw byte for WRITE
    typedef union packed {
        logic [7:0] addr;
        logic [7:0] data;
    } payload_u;

endpackage

`default_nettype wire

//--- design/byte_fifo.sv
// Show-ahead synchronous FIFO
`timescale 1ns/100ps
`default_nettype none

module byte_fifo #(
    parameter int WIDTH = 8,
    parameter int DEPTH = 8
) (
    input  wire logic             clk,
    input  wire logic             rst_sync,
    input  wire logic             push,
    input  wire logic [WIDTH-1:0] push_data,
    input  wire logic             pop,
    output logic      [WIDTH-1:0] head_data,
    output logic                  full,
    output logic                  empty
);

    localparam int AW = $clog2(DEPTH);

    logic [WIDTH-1:0] mem [DEPTH];
    logic [AW:0]      wr_ptr;
    logic [AW:0]      rd_ptr;
    logic             do_push;
    logic             do_pop;

    // Extra pointer bit separates a full lap from an empty queue
    assign empty = (wr_ptr == rd_ptr);
    assign full  = (wr_ptr[AW] != rd_ptr[AW]) && (wr_ptr[AW-1:0] == rd_ptr[AW-1:0]);

    // Writes into a full queue are dropped
    assign do_push = push && !full;
    assign do_pop  = pop && !empty;

    // Head entry is visible without a read strobe
    assign head_data = mem[rd_ptr[AW-1:0]];

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr[AW-1:0]] <= push_data;
        end
    end

    always_ff @(posedge clk) begin
        if (rst_sync) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    // Consumers only pop when something is there
    a_pop_not_empty: assert property (@(posedge clk) disable iff (rst_sync)
        pop |-> !empty);

endmodule

`default_nettype wire

//--- design/i2c_bit_engine.sv
// I2C command sequencer and bit timing
`timescale 1ns/100ps
`default_nettype none

module i2c_bit_engine #(
    parameter int CLK_DIV = 4
) (
    input  wire logic                             clk,
    input  wire logic                             rst_sync,
    input  wire logic [i2c_ctrl_pkg::ENTRY_W-1:0] cmd_entry,
    input  wire logic                             cmd_empty,
    input  wire logic                             rx_full,
    input  wire logic                             scl_in,
    input  wire logic                             sda_in,
    output logic                                  cmd_pop,
    output logic                                  rx_push,
    output logic      [7:0]                       rx_data,
    output logic                                  nack_event,
    output logic                                  busy,
    output logic                                  scl_oe,
    output logic                                  sda_oe
);

    localparam int DIV_W = $clog2(CLK_DIV + 1);

    localparam logic [2:0] ST_IDLE      = 3'd0;
    localparam logic [2:0] ST_START     = 3'd1;
    localparam logic [2:0] ST_SEND_BYTE = 3'd2;
    localparam logic [2:0] ST_GET_ACK   = 3'd3;
    localparam logic [2:0] ST_RECV_BYTE = 3'd4;
    localparam logic [2:0] ST_SEND_ACK  = 3'd5;
    localparam logic [2:0] ST_STOP      = 3'd6;
    localparam logic [2:0] ST_FLUSH     = 3'd7;

    logic [2:0]                     state;
    logic [1:0]                     phase;
    logic [DIV_W-1:0]               div_cnt;
    logic [2:0]                     bit_cnt;
    logic [7:0]                     shift;
    logic [i2c_ctrl_pkg::CMD_W-1:0] cmd_q;
    logic                           stop_q;
    logic                           nack_q;
    logic                           timed;
    logic                           stall;
    logic                           tick;
    logic                           last_bit;

    logic [i2c_ctrl_pkg::CMD_W-1:0] head_cmd;
    logic                           head_stop;
    i2c_ctrl_pkg::payload_u         head_pay;

    assign head_cmd  = cmd_entry[i2c_ctrl_pkg::ENTRY_W-1 -: i2c_ctrl_pkg::CMD_W];
    assign head_stop = cmd_entry[i2c_ctrl_pkg::STOP_BIT];
    assign head_pay  = cmd_entry[7:0];

    // Quarter-period ticks only run in bus-timed states
    assign timed    = (state != ST_IDLE) && (state != ST_FLUSH);
    // Hold SCL low before the first bit of a read until the rx queue has room
    assign stall    = (state == ST_RECV_BYTE) && (bit_cnt == 3'd0) && (phase == 2'd0) && rx_full;
    assign tick     = timed && !stall && (div_cnt == DIV_W'(CLK_DIV - 1));
    assign last_bit = (bit_cnt == 3'd7);

    assign cmd_pop = ((state == ST_IDLE) || (state == ST_FLUSH)) && !cmd_empty;

    // SCL low in the first half of each bit, released in the second
    always_comb begin
        case (state)
            ST_IDLE:  scl_oe = busy;
            ST_FLUSH: scl_oe = 1'b1;
            ST_START: scl_oe = (phase == 2'd0);
            default:  scl_oe = (phase < 2'd2);
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst_sync) begin
            state      <= ST_IDLE;
            phase      <= '0;
            div_cnt    <= '0;
            bit_cnt    <= '0;
            busy       <= 1'b0;
            sda_oe     <= 1'b0;
            nack_q     <= 1'b0;
            rx_push    <= 1'b0;
            nack_event <= 1'b0;
        end else begin
            rx_push    <= 1'b0;
            nack_event <= 1'b0;

            if (!timed || tick) begin
                div_cnt <= '0;
            end else if (!stall) begin
                div_cnt <= div_cnt + 1'b1;
            end
            if (tick) begin
                phase <= phase + 2'd1;
            end

            case (state)
                ST_IDLE: begin
                    if (!cmd_empty) begin
                        busy    <= 1'b1;
                        cmd_q   <= head_cmd;
                        stop_q  <= head_stop;
                        bit_cnt <= '0;
                        // Payload byte goes out MSB first
                        shift   <= head_pay.data;
                        case (head_cmd)
                            i2c_ctrl_pkg::CMD_START:     state <= ST_START;
                            i2c_ctrl_pkg::CMD_WRITE:     state <= ST_SEND_BYTE;
                            i2c_ctrl_pkg::CMD_READ,
                            i2c_ctrl_pkg::CMD_READ_LAST: state <= ST_RECV_BYTE;
                            default:                     state <= ST_IDLE;
                        endcase
                    end
                end
                ST_FLUSH: begin
                    // Stop once the STOP entry goes out or nothing is left
                    if (cmd_empty || head_stop) begin
                        state <= ST_STOP;
                    end
                end
                ST_START: begin
                    if (tick) begin
                        case (phase)
                            2'd0:    sda_oe <= 1'b0;
                            2'd2:    sda_oe <= 1'b1;
                            2'd3:    state  <= ST_SEND_BYTE;
                            default: ;
                        endcase
                    end
                end
                ST_SEND_BYTE: begin
                    if (tick) begin
                        case (phase)
                            2'd0: sda_oe <= !shift[7];
                            2'd3: begin
                                shift   <= {shift[6:0], 1'b0};
                                bit_cnt <= bit_cnt + 3'd1;
                                if (last_bit) begin
                                    state <= ST_GET_ACK;
                                end
                            end
                            default: ;
                        endcase
                    end
                end
                ST_GET_ACK: begin
                    if (tick) begin
                        case (phase)
                            2'd0: sda_oe <= 1'b0;
                            2'd2: nack_q <= sda_in;
                            2'd3: begin
                                if (nack_q) begin
                                    nack_event <= 1'b1;
                                    state      <= stop_q ? ST_STOP : ST_FLUSH;
                                end else begin
                                    state <= stop_q ? ST_STOP : ST_IDLE;
                                end
                            end
                            default: ;
                        endcase
                    end
                end
                ST_RECV_BYTE: begin
                    if (tick) begin
                        case (phase)
                            2'd0: sda_oe <= 1'b0;
                            2'd2: shift  <= {shift[6:0], sda_in};
                            2'd3: begin
                                bit_cnt <= bit_cnt + 3'd1;
                                if (last_bit) begin
                                    rx_push <= 1'b1;
                                    rx_data <= shift;
                                    state   <= ST_SEND_ACK;
                                end
                            end
                            default: ;
                        endcase
                    end
                end
                ST_SEND_ACK: begin
                    if (tick) begin
                        case (phase)
                            2'd0:    sda_oe <= (cmd_q != i2c_ctrl_pkg::CMD_READ_LAST);
                            2'd3:    state  <= stop_q ? ST_STOP : ST_IDLE;
                            default: ;
                        endcase
                    end
                end
                default: begin
                    // SDA held low under low SCL for STOP, then rises while SCL is high
                    if (tick) begin
                        case (phase)
                            2'd0:    sda_oe <= 1'b1;
                            2'd2:    sda_oe <= 1'b0;
                            2'd3: begin
                                state <= ST_IDLE;
                                busy  <= 1'b0;
                            end
                            default: ;
                        endcase
                    end
                end
            endcase
        end
    end

    // SDA only moves under a high SCL to frame START or STOP
    a_sda_framing: assert property (@(posedge clk) disable iff (rst_sync)
        (!scl_oe && !$past(scl_oe) && (sda_oe != $past(sda_oe)))
        |-> ((state == ST_START) || (state == ST_STOP)));

    // A released SCL reads high without target stretching
    a_scl_released: assert property (@(posedge clk) disable iff (rst_sync)
        (tick && !scl_oe) |-> scl_in);

endmodule

`default_nettype wire

//--- design/int_controller.sv
// Sticky interrupt status
`timescale 1ns/100ps
`default_nettype none

module int_controller (
    input  wire logic                           clk,
    input  wire logic                           rst_sync,
    input  wire logic                           tx_empty,
    input  wire logic                           rx_full,
    input  wire logic                           nack_event,
    input  wire logic [i2c_ctrl_pkg::INT_W-1:0] int_enable,
    input  wire logic [i2c_ctrl_pkg::INT_W-1:0] int_clear,
    output logic                                int_tx_empty,
    output logic                                int_rx_full,
    output logic                                int_error
);

    logic                           tx_empty_q;
    logic                           rx_full_q;
    logic [i2c_ctrl_pkg::INT_W-1:0] events;
    logic [i2c_ctrl_pkg::INT_W-1:0] status;

    // Previous queue levels for edge detection
    always_ff @(posedge clk) begin
        if (rst_sync) begin
            // Tx queue is empty coming out of reset
            tx_empty_q <= 1'b1;
            rx_full_q  <= 1'b0;
        end else begin
            tx_empty_q <= tx_empty;
            rx_full_q  <= rx_full;
        end
    end

    always_comb begin
        events = '0;
        events[i2c_ctrl_pkg::INT_TX_EMPTY] = tx_empty && !tx_empty_q;
        events[i2c_ctrl_pkg::INT_RX_FULL]  = rx_full && !rx_full_q;
        events[i2c_ctrl_pkg::INT_ERROR]    = nack_event;
    end

    // Enabled events set the status and a clear strobe wins
    always_ff @(posedge clk) begin
        if (rst_sync) begin
            status <= '0;
        end else begin
            status <= (status | (events & int_enable)) & ~int_clear;
        end
    end

    assign int_tx_empty = status[i2c_ctrl_pkg::INT_TX_EMPTY];
    assign int_rx_full  = status[i2c_ctrl_pkg::INT_RX_FULL];
    assign int_error    = status[i2c_ctrl_pkg::INT_ERROR];

endmodule

`default_nettype wire

//--- design/i2c_int_controller.sv
// I2C master with interrupt controller
`timescale 1ns/100ps
`default_nettype none

module i2c_int_controller #(
    parameter int FIFO_DEPTH = 8,
    parameter int CLK_DIV    = 4
) (
    input  wire logic                           clk,
    input  wire logic                           rst_sync,
    input  wire logic                           scl_in,
    input  wire logic                           sda_in,
    input  wire logic                           wr_en,
    input  wire logic [i2c_ctrl_pkg::CMD_W-1:0] tx_cmd,
    input  wire logic                           tx_stop,
    input  wire logic [7:0]                     fifo_data_in,
    input  wire logic                           rd_en,
    input  wire logic [i2c_ctrl_pkg::INT_W-1:0] int_enable,
    input  wire logic [i2c_ctrl_pkg::INT_W-1:0] int_clear,
    output wire logic                           scl_oe,
    output wire logic                           sda_oe,
    output wire logic                           tx_full,
    output wire logic [7:0]                     fifo_data_out,
    output wire logic                           rx_empty,
    output wire logic                           busy,
    output wire logic                           int_tx_empty,
    output wire logic                           int_rx_full,
    output wire logic                           int_error
);

    logic [i2c_ctrl_pkg::ENTRY_W-1:0] tx_entry;
    logic [i2c_ctrl_pkg::ENTRY_W-1:0] tx_head;
    logic                             tx_empty;
    logic                             tx_pop;
    logic                             rx_push;
    logic [7:0]                       rx_byte;
    logic                             rx_full;
    logic                             nack_event;

    // Queue entry packs command, stop flag and payload byte
    assign tx_entry = {tx_cmd, tx_stop, fifo_data_in};

    byte_fifo #(
        .WIDTH (i2c_ctrl_pkg::ENTRY_W),
        .DEPTH (FIFO_DEPTH)
    ) tx_fifo_i (
        .clk       (clk),
        .rst_sync  (rst_sync),
        .push      (wr_en),
        .push_data (tx_entry),
        .pop       (tx_pop),
        .head_data (tx_head),
        .full      (tx_full),
        .empty     (tx_empty)
    );

    byte_fifo #(
        .WIDTH (8),
        .DEPTH (FIFO_DEPTH)
    ) rx_fifo_i (
        .clk       (clk),
        .rst_sync  (rst_sync),
        .push      (rx_push),
        .push_data (rx_byte),
        .pop       (rd_en),
        .head_data (fifo_data_out),
        .full      (rx_full),
        .empty     (rx_empty)
    );

    i2c_bit_engine #(
        .CLK_DIV (CLK_DIV)
    ) i2c_bit_engine_i (
        .clk        (clk),
        .rst_sync   (rst_sync),
        .cmd_entry  (tx_head),
        .cmd_empty  (tx_empty),
        .rx_full    (rx_full),
        .scl_in     (scl_in),
        .sda_in     (sda_in),
        .cmd_pop    (tx_pop),
        .rx_push    (rx_push),
        .rx_data    (rx_byte),
        .nack_event (nack_event),
        .busy       (busy),
        .scl_oe     (scl_oe),
        .sda_oe     (sda_oe)
    );

    int_controller int_controller_i (
        .clk          (clk),
        .rst_sync     (rst_sync),
        .tx_empty     (tx_empty),
        .rx_full      (rx_full),
        .nack_event   (nack_event),
        .int_enable   (int_enable),
        .int_clear    (int_clear),
        .int_tx_empty (int_tx_empty),
        .int_rx_full  (int_rx_full),
        .int_error    (int_error)
    );

endmodule

`default_nettype wire

//--- bench/i2c_target_model.sv
// Behavioral I2C target
`timescale 1ns/100ps
`default_nettype none

module i2c_target_model #(
    parameter logic [6:0] ADDR = 7'h2a
) (
    input  wire logic clk,
    input  wire logic rst_sync,
    input  wire logic master_scl_oe,
    input  wire logic master_sda_oe,
    output logic      scl,
    output logic      sda
);

    localparam logic [1:0] T_IDLE = 2'd0;
    localparam logic [1:0] T_RX   = 2'd1;
    localparam logic [1:0] T_TX   = 2'd2;

    logic [7:0] mem [256];
    logic [1:0] state;
    logic [3:0] cnt;
    logic [7:0] shift;
    logic [7:0] tx_byte;
    logic [7:0] ptr;
    logic       ptr_set;
    logic       in_addr;
    logic       to_tx;
    logic       master_nack;
    logic       sda_oe;
    logic       scl_q;
    logic       sda_q;
    logic       start_cond;
    logic       stop_cond;
    logic       scl_rise;
    logic       scl_fall;

    // Wired-AND bus with pull-ups, the target never stretches SCL
    assign scl = !master_scl_oe;
    assign sda = !(master_sda_oe || sda_oe);

    assign start_cond = scl_q && scl && sda_q && !sda;
    assign stop_cond  = scl_q && scl && !sda_q && sda;
    assign scl_rise   = !scl_q && scl;
    assign scl_fall   = scl_q && !scl;

    // cnt counts SCL rises since the last START or byte boundary
    always @(posedge clk) begin
        if (rst_sync) begin
            for (int i = 0; i < 256; i++) begin
                mem[i] <= 8'(i) ^ 8'ha5;
            end
            state       <= T_IDLE;
            cnt         <= '0;
            shift       <= '0;
            tx_byte     <= '0;
            ptr         <= '0;
            ptr_set     <= 1'b0;
            in_addr     <= 1'b0;
            to_tx       <= 1'b0;
            master_nack <= 1'b0;
            sda_oe      <= 1'b0;
            scl_q       <= 1'b1;
            sda_q       <= 1'b1;
        end else begin
            scl_q <= scl;
            sda_q <= sda;
            if (start_cond) begin
                state   <= T_RX;
                cnt     <= '0;
                in_addr <= 1'b1;
                ptr_set <= 1'b0;
                to_tx   <= 1'b0;
                sda_oe  <= 1'b0;
            end else if (stop_cond) begin
                state  <= T_IDLE;
                sda_oe <= 1'b0;
            end else if (scl_rise && (state != T_IDLE)) begin
                cnt <= cnt + 4'd1;
                if ((state == T_RX) && (cnt < 4'd8)) begin
                    shift <= {shift[6:0], sda};
                end
                if ((state == T_TX) && (cnt == 4'd8)) begin
                    master_nack <= sda;
                end
            end else if (scl_fall && (state != T_IDLE) && (cnt != 4'd0)) begin
                if (state == T_RX) begin
                    if (cnt == 4'd8) begin
                        if (in_addr) begin
                            in_addr <= 1'b0;
                            if (shift[7:1] == ADDR) begin
                                sda_oe <= 1'b1;
                                to_tx  <= shift[0];
                            end else begin
                                // Not our address, stay off the bus
                                state <= T_IDLE;
                            end
                        end else begin
                            sda_oe <= 1'b1;
                            if (!ptr_set) begin
                                ptr     <= shift;
                                ptr_set <= 1'b1;
                            end else begin
                                mem[ptr] <= shift;
                                ptr      <= ptr + 8'd1;
                            end
                        end
                    end else if (cnt == 4'd9) begin
                        cnt <= '0;
                        if (to_tx) begin
                            to_tx   <= 1'b0;
                            state   <= T_TX;
                            tx_byte <= mem[ptr];
                            sda_oe  <= !mem[ptr][7];
                            ptr     <= ptr + 8'd1;
                        end else begin
                            sda_oe <= 1'b0;
                        end
                    end
                end else begin
                    if (cnt < 4'd8) begin
                        sda_oe <= !tx_byte[3'd7 - cnt[2:0]];
                    end else if (cnt == 4'd8) begin
                        // Release for the master ACK bit
                        sda_oe <= 1'b0;
                    end else begin
                        cnt <= '0;
                        if (master_nack) begin
                            state  <= T_IDLE;
                            sda_oe <= 1'b0;
                        end else begin
                            tx_byte <= mem[ptr];
                            sda_oe  <= !mem[ptr][7];
                            ptr     <= ptr + 8'd1;
                        end
                    end
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- bench/tb_i2c_int_controller.sv
// I2C interrupt controller testbench
`timescale 1ns/100ps
`default_nettype none

module tb_i2c_int_controller;

    localparam int FIFO_DEPTH = 8;
    localparam int CLK_DIV    = 4;
    localparam int WAIT_LIMIT = 20000;

    logic                           clk = 1'b0;
    logic                           rst_sync;
    logic                           scl_bus;
    logic                           sda_bus;
    logic                           wr_en;
    logic [i2c_ctrl_pkg::CMD_W-1:0] tx_cmd;
    logic                           tx_stop;
    logic [7:0]                     fifo_data_in;
    logic                           rd_en;
    logic [i2c_ctrl_pkg::INT_W-1:0] int_enable;
    logic [i2c_ctrl_pkg::INT_W-1:0] int_clear;
    logic                           scl_oe;
    logic                           sda_oe;
    logic                           tx_full;
    logic [7:0]                     fifo_data_out;
    logic                           rx_empty;
    logic                           busy;
    logic                           int_tx_empty;
    logic                           int_rx_full;
    logic                           int_error;
    logic [i2c_ctrl_pkg::INT_W-1:0] int_vec;

    always #4 clk = ~clk;

    always_comb begin
        int_vec = '0;
        int_vec[i2c_ctrl_pkg::INT_TX_EMPTY] = int_tx_empty;
        int_vec[i2c_ctrl_pkg::INT_RX_FULL]  = int_rx_full;
        int_vec[i2c_ctrl_pkg::INT_ERROR]    = int_error;
    end

    i2c_int_controller #(
        .FIFO_DEPTH (FIFO_DEPTH),
        .CLK_DIV    (CLK_DIV)
    ) i2c_int_controller_i (
        .clk           (clk),
        .rst_sync      (rst_sync),
        .scl_in        (scl_bus),
        .sda_in        (sda_bus),
        .wr_en         (wr_en),
        .tx_cmd        (tx_cmd),
        .tx_stop       (tx_stop),
        .fifo_data_in  (fifo_data_in),
        .rd_en         (rd_en),
        .int_enable    (int_enable),
        .int_clear     (int_clear),
        .scl_oe        (scl_oe),
        .sda_oe        (sda_oe),
        .tx_full       (tx_full),
        .fifo_data_out (fifo_data_out),
        .rx_empty      (rx_empty),
        .busy          (busy),
        .int_tx_empty  (int_tx_empty),
        .int_rx_full   (int_rx_full),
        .int_error     (int_error)
    );

    i2c_target_model #(
        .ADDR (7'h2a)
    ) target_i (
        .clk           (clk),
        .rst_sync      (rst_sync),
        .master_scl_oe (scl_oe),
        .master_sda_oe (sda_oe),
        .scl           (scl_bus),
        .sda           (sda_bus)
    );

    task automatic end_in_failure();
        $display("Regression failed");
        $fatal(1);
    endtask

    task automatic timeout_fail(input string what);
        $display("Timed out waiting for %s", what);
        end_in_failure();
    endtask

    task automatic check_byte(input string name, input logic [7:0] got, input logic [7:0] exp);
        if (got !== exp) begin
            $display("[FAIL] %s got 0x%02h expected 0x%02h", name, got, exp);
            end_in_failure();
        end
    endtask

    task automatic check_int(input string name, input logic [i2c_ctrl_pkg::INT_W-1:0] got,
                             input logic [i2c_ctrl_pkg::INT_W-1:0] exp);
        if (got !== exp) begin
            $display("[FAIL] %s got 0x%01h expected 0x%01h", name, got, exp);
            end_in_failure();
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("[FAIL] %s got 0x%01h expected 0x%01h", name, got, exp);
            end_in_failure();
        end
    endtask

    // Every step lands 1 ns after a rising edge
    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic push_cmd(input logic [i2c_ctrl_pkg::CMD_W-1:0] cmd, input logic stop,
                            input logic [7:0] data);
        int n;
        n = 0;
        while (tx_full && (n < WAIT_LIMIT)) begin
            next_cycle();
            n++;
        end
        if (tx_full) begin
            timeout_fail("room in the command queue");
        end
        wr_en        = 1'b1;
        tx_cmd       = cmd;
        tx_stop      = stop;
        fifo_data_in = data;
        next_cycle();
        wr_en = 1'b0;
    endtask

    task automatic wait_idle();
        int n;
        n = 0;
        do begin
            next_cycle();
            n++;
        end while (busy && (n < WAIT_LIMIT));
        if (busy) begin
            timeout_fail("the engine to release the bus");
        end
    endtask

    task automatic pop_expect(input logic [7:0] exp);
        int n;
        n = 0;
        do begin
            next_cycle();
            n++;
        end while (rx_empty && (n < WAIT_LIMIT));
        if (rx_empty) begin
            timeout_fail("a received byte");
        end
        check_byte("fifo_data_out", fifo_data_out, exp);
        rd_en = 1'b1;
        next_cycle();
        rd_en = 1'b0;
    endtask

    task automatic wait_int(input logic [i2c_ctrl_pkg::INT_W-1:0] exp);
        int n;
        n = 0;
        while ((int_vec !== exp) && (n < WAIT_LIMIT)) begin
            next_cycle();
            n++;
        end
        if (int_vec !== exp) begin
            timeout_fail("the expected interrupt vector");
        end
    endtask

    task automatic clear_int(input logic [i2c_ctrl_pkg::INT_W-1:0] mask);
        int_clear = mask;
        next_cycle();
        int_clear = '0;
    endtask

    initial begin
        int               fd;
        int               n;
        logic [7:0]       op;
        logic [31:0]      a;
        logic [31:0]      b;
        logic [31:0]      c;
        logic [8*128-1:0] rest;

        rst_sync     = 1'b1;
        wr_en        = 1'b0;
        tx_cmd       = '0;
        tx_stop      = 1'b0;
        fifo_data_in = '0;
        rd_en        = 1'b0;
        int_enable   = '0;
        int_clear    = '0;
        repeat (16) @(posedge clk);
        #1;
        rst_sync = 1'b0;

        // Idle bus and quiet interrupts out of reset
        check_int("int_vec", int_vec, '0);
        check_bit("busy", busy, 1'b0);
        check_bit("scl_oe", scl_oe, 1'b0);
        check_bit("sda_oe", sda_oe, 1'b0);
        check_bit("rx_empty", rx_empty, 1'b1);
        check_bit("tx_full", tx_full, 1'b0);

        fd = $fopen("bench/i2c_golden_vectors.txt", "r");
        if (fd == 0) begin
            $display("Could not open the golden vector file");
            end_in_failure();
        end
        while ($fscanf(fd, " %s", op) == 1) begin
            a = '0;
            b = '0;
            c = '0;
            case (op)
                "#": n = $fgets(rest, fd);
                "P": begin
                    n = $fscanf(fd, " %h %h %h", a, b, c);
                    push_cmd(a[i2c_ctrl_pkg::CMD_W-1:0], b[0], c[7:0]);
                end
                "W": wait_idle();
                "X": begin
                    n = $fscanf(fd, " %h", a);
                    pop_expect(a[7:0]);
                end
                "C": begin
                    n = $fscanf(fd, " %h", a);
                    check_int("int_vec", int_vec, a[i2c_ctrl_pkg::INT_W-1:0]);
                end
                "Q": begin
                    n = $fscanf(fd, " %h", a);
                    wait_int(a[i2c_ctrl_pkg::INT_W-1:0]);
                end
                "B": begin
                    n = $fscanf(fd, " %h", a);
                    check_bit("busy", busy, a[0]);
                end
                "E": begin
                    n = $fscanf(fd, " %h", a);
                    int_enable = a[i2c_ctrl_pkg::INT_W-1:0];
                end
                "K": begin
                    n = $fscanf(fd, " %h", a);
                    clear_int(a[i2c_ctrl_pkg::INT_W-1:0]);
                end
                "M": begin
                    n = $fscanf(fd, " %h %h", a, b);
                    check_byte($sformatf("target mem[0x%02h]", a[7:0]),
                               target_i.mem[a[7:0]], b[7:0]);
                end
                default: begin
                    $display("Unknown operation in the golden vector file");
                    end_in_failure();
                end
            endcase
        end
        $fclose(fd);
        $display("Regression passed");
        $finish;
    end

endmodule

`default_nettype wire

//--- bench/i2c_golden_vectors.txt
# P cmd stop byte | W wait idle | X expected rx byte | C check int vector | Q wait int vector
# B busy level | E int enable | K int clear | M target addr expected byte (all hex)
E 7
P 0 0 54
P 1 0 03
P 1 0 c3
P 1 0 5e
P 1 1 96
W
C 1
M 03 c3
M 04 5e
M 05 96
K 7
C 0
P 0 0 54
P 1 0 03
P 0 0 55
P 2 0 00
P 2 0 00
P 3 1 00
W
X c3
X 5e
X 96
C 1
K 7
C 0
P 0 0 22
P 1 0 10
P 1 1 ee
W
C 5
M 10 b5
K 7
C 0
P 0 0 54
P 1 0 20
P 1 1 7b
W
C 1
M 20 7b
K 7
C 0
P 0 0 54
P 1 0 02
P 0 0 55
P 2 0 00
P 2 0 00
P 2 0 00
P 2 0 00
P 2 0 00
P 2 0 00
P 2 0 00
P 2 0 00
P 2 0 00
P 3 1 00
Q 2
B 1
X a7
X c3
X 5e
X 96
X a3
X a2
X ad
X ac
X af
X ae
W
C 3
K 7
C 0
E 6
P 0 0 54
P 1 0 06
P 1 1 3c
W
C 0
M 06 3c

//--- tb.f
design/i2c_ctrl_pkg.sv
design/byte_fifo.sv
design/i2c_bit_engine.sv
design/int_controller.sv
design/i2c_int_controller.sv
bench/i2c_target_model.sv
bench/tb_i2c_int_controller.sv

//--- run_sim.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_i2c_int_controller \
    -f tb.f -o sim_tb

./obj_dir/sim_tb > sim.log 2>&1 || true
cat sim.log

if grep -q "Regression passed" sim.log; then
    exit 0
else
    exit 1
fi
